/* rvIsaPkg.sv */
// RV32I base encodings only; no M, CSR or compressed codes, and instruction bits 1:0 are ignored
package rvIsaPkg;

   // ************************************************************
   // Word and register file geometry
   // ************************************************************
   localparam int XLEN      = 32;     // Data word width
   localparam int NUM_REGS  = 32;     // x0..x31
   localparam int REG_IDX_W = 5;      // Register index width

   // ************************************************************
   // Major opcodes, instruction bits 6:2
   // ************************************************************
   localparam logic [4:0] OPC_LOAD   = 5'b00000;   // rd <- mem[rs1+Iimm]
   localparam logic [4:0] OPC_OPIMM  = 5'b00100;   // rd <- rs1 OP Iimm
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;   // rd <- PC + Uimm
   localparam logic [4:0] OPC_STORE  = 5'b01000;   // mem[rs1+Simm] <- rs2
   localparam logic [4:0] OPC_OP     = 5'b01100;   // rd <- rs1 OP rs2
   localparam logic [4:0] OPC_LUI    = 5'b01101;   // rd <- Uimm
   localparam logic [4:0] OPC_BRANCH = 5'b11000;   // if (rs1 OP rs2) PC <- PC + Bimm
   localparam logic [4:0] OPC_JALR   = 5'b11001;   // rd <- PC+4; PC <- rs1 + Iimm
   localparam logic [4:0] OPC_JAL    = 5'b11011;   // rd <- PC+4; PC <- PC + Jimm

   // ALU function codes
   localparam logic [2:0] F3_ADD  = 3'b000;   // ADD, SUB, ADDI
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101;   // SRL or SRA, bit 30 picks
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   // Branch conditions
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // ************************************************************
   // One instruction word, two field layouts
   // ************************************************************
   typedef union packed {
      struct packed {                 // R view, also source of S, B, U, J bits
         logic [6:0]           funct7;
         logic [REG_IDX_W-1:0] rs2;
         logic [REG_IDX_W-1:0] rs1;
         logic [2:0]           funct3;
         logic [REG_IDX_W-1:0] rd;
         logic [6:0]           opcode;
      } r;
      struct packed {                 // I view
         logic [11:0]          imm;
         logic [REG_IDX_W-1:0] rs1;
         logic [2:0]           funct3;
         logic [REG_IDX_W-1:0] rd;
         logic [6:0]           opcode;
      } i;
   } instrWord_t;

endpackage

/* corePkg.sv */
// Core build constants; addresses above ADDR_WIDTH bits are not reachable and read back as zero
package corePkg;

   // ************************************************************
   // Address space
   // ************************************************************
   localparam int ADDR_WIDTH = 24;                        // Internal address bits
   localparam logic [ADDR_WIDTH-1:0] RESET_ADDR = '0;     // First fetch address

   // ************************************************************
   // One-hot state bit positions
   // ************************************************************
   localparam int ST_FETCH      = 0;   // Read strobe at PC
   localparam int ST_WAIT_INSTR = 1;   // Hold until read not busy
   localparam int ST_EXECUTE    = 2;   // Single cycle ALU / branch / jump
   localparam int ST_LOAD       = 3;   // Read strobe at data address
   localparam int ST_STORE      = 4;   // Write mask at data address
   localparam int ST_WAIT_MEM   = 5;   // Hold until both busy levels drop

   localparam int NUM_STATES    = 6;

endpackage

/* execBus.sv */
// Single-instruction handshake between sequencer and execution unit; no valid/ready, strobes only
`timescale 1ns/1ps

interface execBus import rvIsaPkg::*, corePkg::*; ();

   // Sequencer to execution unit
   instrWord_t            instr;        // Latched instruction
   logic [ADDR_WIDTH-1:0] pc;           // PC of that instruction
   logic                  execute;      // One cycle, execute state
   logic                  storePhase;   // High during the store state
   logic                  loadDone;     // Pulse when load data is valid

   // Execution unit back to sequencer
   logic [ADDR_WIDTH-1:0] nextPc;       // Branch / jump / fall-through target
   logic [ADDR_WIDTH-1:0] dataAddr;     // rs1 + offset for load and store
   logic                  isLoad;
   logic                  isStore;

   modport seqSide (
      output instr, pc, execute, storePhase, loadDone,
      input  nextPc, dataAddr, isLoad, isStore
   );

   modport execSide (
      input  instr, pc, execute, storePhase, loadDone,
      output nextPc, dataAddr, isLoad, isStore
   );

endinterface

/* coreSequencer.sv */
// Waits on memRbusy/memWbusy levels only; memory must hold read data until busy drops
`timescale 1ns/1ps

module coreSequencer import rvIsaPkg::*, corePkg::*; (
   input  logic                  clk,
   input  logic                  reset,       // Sync, active low
   execBus.seqSide               bus,
   input  logic [XLEN-1:0]       memRdata,    // Instruction word on fetch
   input  logic                  memRbusy,
   input  logic                  memWbusy,
   output logic                  memRstrb,
   output logic [ADDR_WIDTH-1:0] memAddr,
   output logic                  fetchDone    // Operand latch enable for regFile
);

   logic [NUM_STATES-1:0] state;           // One-hot
   logic [ADDR_WIDTH-1:0] pc;
   logic [ADDR_WIDTH-1:0] addrReg;         // Drives memAddr
   instrWord_t            instr;
   logic                  loadPending;     // Wait state belongs to a load
   logic                  memIdle;

   assign memIdle   = !memRbusy && !memWbusy;
   assign fetchDone = state[ST_WAIT_INSTR] && !memRbusy;     // Word accepted this cycle
   assign memRstrb  = state[ST_FETCH] || state[ST_LOAD];
   assign memAddr   = addrReg;

   assign bus.instr      = instr;
   assign bus.pc         = pc;
   assign bus.execute    = state[ST_EXECUTE];
   assign bus.storePhase = state[ST_STORE];
   assign bus.loadDone   = state[ST_WAIT_MEM] && memIdle && loadPending;

   // ************************************************************
   // State, PC and load tracking
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state       <= NUM_STATES'(1) << ST_WAIT_MEM;   // Exit once memory is idle
         pc          <= RESET_ADDR;
         loadPending <= 1'b0;
      end else begin
         case (1'b1)
            state[ST_FETCH]: state <= NUM_STATES'(1) << ST_WAIT_INSTR;
            state[ST_WAIT_INSTR]: begin
               if (!memRbusy) state <= NUM_STATES'(1) << ST_EXECUTE;
            end
            state[ST_EXECUTE]: begin
               pc    <= bus.nextPc;
               state <= bus.isLoad  ? NUM_STATES'(1) << ST_LOAD  :
                        bus.isStore ? NUM_STATES'(1) << ST_STORE :
                                      NUM_STATES'(1) << ST_FETCH;
            end
            state[ST_LOAD]: begin
               loadPending <= 1'b1;                      // Write-back at end of wait
               state       <= NUM_STATES'(1) << ST_WAIT_MEM;
            end
            state[ST_STORE]: state <= NUM_STATES'(1) << ST_WAIT_MEM;
            state[ST_WAIT_MEM]: begin
               if (memIdle) begin
                  loadPending <= 1'b0;
                  state       <= NUM_STATES'(1) << ST_FETCH;
               end
            end
         endcase
      end
   end

   // ************************************************************
   // Address register and instruction latch
   // ************************************************************
   always_ff @(posedge clk) begin
      if (fetchDone) instr <= memRdata;                  // Bits 1:0 kept but never decoded
      if (state[ST_EXECUTE]) begin
         // Data address for memory ops, else straight to the next fetch
         addrReg <= (bus.isLoad || bus.isStore) ? bus.dataAddr : bus.nextPc;
      end
      if (state[ST_WAIT_MEM] && memIdle) addrReg <= pc;  // Back to PC for fetch
   end

endmodule

/* regFile.sv */
// Registers have no reset and hold X until written; x0 is forced to zero on read
`timescale 1ns/1ps

module regFile import rvIsaPkg::*; (
   input  logic                 clk,
   input  logic                 fetchDone,    // Latch operands of fetched word
   input  instrWord_t           fetched,      // Raw memory word at fetch
   output logic [XLEN-1:0]      rs1Data,
   output logic [XLEN-1:0]      rs2Data,
   input  logic                 regWrite,
   input  logic [REG_IDX_W-1:0] rd,
   input  logic [XLEN-1:0]      wbData
);

   logic [XLEN-1:0] regs [NUM_REGS];

   // Write port, x0 writes dropped
   always_ff @(posedge clk) begin
      if (regWrite && rd != '0) regs[rd] <= wbData;
   end

   // Operand latches, valid the cycle after fetchDone
   always_ff @(posedge clk) begin
      if (fetchDone) begin
         rs1Data <= (fetched.r.rs1 == '0) ? '0 : regs[fetched.r.rs1];
         rs2Data <= (fetched.r.rs2 == '0) ? '0 : regs[fetched.r.rs2];
      end
   end

endmodule

/* execUnit.sv */
// Combinational RV32I datapath; word-only memory access, funct3 ignored on load/store
`timescale 1ns/1ps

module execUnit import rvIsaPkg::*, corePkg::*; (
   execBus.execSide             bus,
   input  logic [XLEN-1:0]      rs1Data,
   input  logic [XLEN-1:0]      rs2Data,
   input  logic [XLEN-1:0]      memRdata,    // Load data
   output logic                 regWrite,
   output logic [REG_IDX_W-1:0] rd,
   output logic [XLEN-1:0]      wbData,
   output logic [XLEN-1:0]      memWdata,
   output logic [3:0]           memWmask
);

   // Bit reversal, lets one right shifter serve SLL too
   function automatic logic [XLEN-1:0] flip(input logic [XLEN-1:0] x);
      logic [XLEN-1:0] y;
      for (int k = 0; k < XLEN; k++) begin
         y[k] = x[XLEN-1-k];
      end
      return y;
   endfunction

   instrWord_t            instr;
   logic [4:0]            opc;
   logic [2:0]            funct3;
   logic                  isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic                  isLui, isBranch, isJalr, isJal;
   logic [XLEN-1:0]       iImm, sImm, bImm, uImm, jImm;
   logic [XLEN-1:0]       aluIn2, plus, aluOut, shifterIn, shifter, leftShift;
   logic [XLEN:0]         minus, shiftWide;
   logic                  lt, ltu, eq, predicate, isSub, isSra;
   logic [XLEN-1:0]       pcImm, addrImm, auipcValue;
   logic [ADDR_WIDTH-1:0] pcPlus4, pcPlusImm, rs1PlusImm;

   assign instr  = bus.instr;
   assign opc    = instr.r.opcode[6:2];
   assign funct3 = instr.r.funct3;
   assign rd     = instr.r.rd;

   // ************************************************************
   // Decode and immediates
   // ************************************************************
   assign isLoad   = (opc == OPC_LOAD);
   assign isAluImm = (opc == OPC_OPIMM);
   assign isAuipc  = (opc == OPC_AUIPC);
   assign isStore  = (opc == OPC_STORE);
   assign isAluReg = (opc == OPC_OP);
   assign isLui    = (opc == OPC_LUI);
   assign isBranch = (opc == OPC_BRANCH);
   assign isJalr   = (opc == OPC_JALR);
   assign isJal    = (opc == OPC_JAL);

   assign iImm = {{20{instr.i.imm[11]}}, instr.i.imm};
   assign sImm = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
   assign bImm = {{20{instr.r.funct7[6]}}, instr.r.rd[0], instr.r.funct7[5:0],
                  instr.r.rd[4:1], 1'b0};
   assign uImm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
   assign jImm = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                  instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

   // ************************************************************
   // ALU, one 33-bit subtract covers SUB and every compare
   // ************************************************************
   assign aluIn2 = isAluImm ? iImm : rs2Data;
   assign isSub  = isAluReg && instr.r.funct7[5];      // ADDI has bit 30 as immediate
   assign isSra  = instr.r.funct7[5];
   assign plus   = rs1Data + aluIn2;
   assign minus  = {1'b1, ~aluIn2} + {1'b0, rs1Data} + (XLEN+1)'(1);
   assign ltu    = minus[XLEN];                        // Borrow out
   assign lt     = (rs1Data[XLEN-1] ^ aluIn2[XLEN-1]) ? rs1Data[XLEN-1] : ltu;
   assign eq     = (minus[XLEN-1:0] == '0);

   assign shifterIn = funct3[2] ? rs1Data : flip(rs1Data);
   assign shiftWide = $signed({isSra & rs1Data[XLEN-1], shifterIn}) >>> aluIn2[4:0];
   assign shifter   = shiftWide[XLEN-1:0];
   assign leftShift = flip(shifter);

   always_comb begin
      case (funct3)
         F3_ADD:  aluOut = isSub ? minus[XLEN-1:0] : plus;
         F3_SLL:  aluOut = leftShift;
         F3_SLT:  aluOut = {{(XLEN-1){1'b0}}, lt};
         F3_SLTU: aluOut = {{(XLEN-1){1'b0}}, ltu};
         F3_XOR:  aluOut = rs1Data ^ aluIn2;
         F3_SR:   aluOut = shifter;                    // SRL / SRA
         F3_OR:   aluOut = rs1Data | aluIn2;
         default: aluOut = rs1Data & aluIn2;           // F3_AND
      endcase
   end

   always_comb begin
      case (funct3)
         F3_BEQ:  predicate = eq;
         F3_BNE:  predicate = !eq;
         F3_BLT:  predicate = lt;
         F3_BGE:  predicate = !lt;
         F3_BLTU: predicate = ltu;
         F3_BGEU: predicate = !ltu;
         default: predicate = 1'b0;                    // Reserved codes never taken
      endcase
   end

   // ************************************************************
   // Targets and write-back
   // ************************************************************
   assign pcPlus4    = bus.pc + ADDR_WIDTH'(4);
   assign pcImm      = isJal ? jImm : bImm;
   assign pcPlusImm  = bus.pc + pcImm[ADDR_WIDTH-1:0];
   assign addrImm    = isStore ? sImm : iImm;
   assign rs1PlusImm = rs1Data[ADDR_WIDTH-1:0] + addrImm[ADDR_WIDTH-1:0];
   assign auipcValue = XLEN'(bus.pc) + uImm;           // Full 32-bit sum

   assign bus.nextPc   = isJalr ? {rs1PlusImm[ADDR_WIDTH-1:1], 1'b0} :
                         (isJal || (isBranch && predicate)) ? pcPlusImm : pcPlus4;
   assign bus.dataAddr = rs1PlusImm;
   assign bus.isLoad   = isLoad;
   assign bus.isStore  = isStore;

   always_comb begin
      wbData = aluOut;                                 // OP and OP-IMM
      if (isLui)                wbData = uImm;
      else if (isAuipc)         wbData = auipcValue;
      else if (isJal || isJalr) wbData = XLEN'(pcPlus4);   // Link value
      else if (isLoad)          wbData = memRdata;
   end

   // Loads write only at the end of the wait state
   assign regWrite = (bus.execute && !(isBranch || isStore || isLoad)) || bus.loadDone;

   assign memWdata = rs2Data;                          // Qualified by the mask
   assign memWmask = {4{bus.storePhase}};              // Whole word always

endmodule

/* femtoCore.sv */
// RV32I core, word access only; memory answers memRstrb and holds busy levels while not ready
`timescale 1ns/1ps

module femtoCore import rvIsaPkg::*, corePkg::*; (
   input  logic            clk,
   input  logic            reset,       // Sync, active low
   output logic [XLEN-1:0] memAddr,
   output logic [XLEN-1:0] memWdata,
   output logic [3:0]      memWmask,
   output logic            memRstrb,
   input  logic [XLEN-1:0] memRdata,    // Shared by fetch and load
   input  logic            memRbusy,
   input  logic            memWbusy
);

   logic [ADDR_WIDTH-1:0] addrReg;
   logic                  fetchDone;
   logic                  regWrite;
   logic [REG_IDX_W-1:0]  rdIdx;
   logic [XLEN-1:0]       rs1Data, rs2Data, wbData;

   execBus u_execBus ();

   assign memAddr = {{(XLEN-ADDR_WIDTH){1'b0}}, addrReg};   // Upper bits zero

   coreSequencer u_coreSequencer (
      .clk       (clk),
      .reset     (reset),
      .bus       (u_execBus.seqSide),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .memRstrb  (memRstrb),
      .memAddr   (addrReg),
      .fetchDone (fetchDone)
   );

   regFile u_regFile (
      .clk       (clk),
      .fetchDone (fetchDone),
      .fetched   (memRdata),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .regWrite  (regWrite),
      .rd        (rdIdx),
      .wbData    (wbData)
   );

   execUnit u_execUnit (
      .bus       (u_execBus.execSide),
      .rs1Data   (rs1Data),
      .rs2Data   (rs2Data),
      .memRdata  (memRdata),
      .regWrite  (regWrite),
      .rd        (rdIdx),
      .wbData    (wbData),
      .memWdata  (memWdata),
      .memWmask  (memWmask)
   );

endmodule

/* tbProgramTable.svh */
// Programs start at address 0; body words at 0..5, result store to 0x100 at 6, self-jump at 7
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

// Columns: row, test name, expected word, then the program or its operands
task automatic buildTable();
   // ************************************************************
   // ALU, operands OPA and OPB preloaded into x1 and x2
   // ************************************************************
   setRow(0, "ADDI", OPA + 100, 3, addi(1, 0, OPA), addi(3, 1, 100), nop(), nop(), nop(), nop());
   aluRow(1, "ADD",  F3_ADD,  0,  OPA + OPB);
   aluRow(2, "SUB",  F3_ADD,  32, OPA - OPB);
   aluRow(3, "XOR",  F3_XOR,  0,  OPA ^ OPB);
   aluRow(4, "OR",   F3_OR,   0,  OPA | OPB);
   aluRow(5, "AND",  F3_AND,  0,  OPA & OPB);
   aluRow(6, "SLT",  F3_SLT,  0,  (OPA < OPB) ? 1 : 0);                    // Signed
   aluRow(7, "SLTU", F3_SLTU, 0,  ($unsigned(OPA) < $unsigned(OPB)) ? 1 : 0);
   aluRow(8, "SLL",  F3_SLL,  0,  OPA << OPB);
   aluRow(9, "SRL",  F3_SR,   0,  OPA >> OPB);                              // Zero fill
   aluRow(10, "SRA", F3_SR,   32, OPA >>> OPB);                             // Sign fill

   // ************************************************************
   // Branches, marker 1 when taken, 2 when not
   // ************************************************************
   branchRow(11, "BEQ taken",      F3_BEQ,  5, 5);
   branchRow(12, "BEQ not taken",  F3_BEQ,  5, 6);
   branchRow(13, "BNE taken",      F3_BNE,  5, 6);
   branchRow(14, "BNE not taken",  F3_BNE,  5, 5);
   branchRow(15, "BLT taken",      F3_BLT,  -3, 2);
   branchRow(16, "BLT not taken",  F3_BLT,  2, -3);
   branchRow(17, "BGE taken",      F3_BGE,  2, -3);
   branchRow(18, "BGE not taken",  F3_BGE,  -3, 2);
   branchRow(19, "BLTU taken",     F3_BLTU, 2, -3);
   branchRow(20, "BLTU not taken", F3_BLTU, -3, 2);
   branchRow(21, "BGEU taken",     F3_BGEU, -3, 2);
   branchRow(22, "BGEU not taken", F3_BGEU, 2, -3);

   // Jumps land on the store at 24, link is PC+4
   setRow(23, "JAL", 0 + 4, 3, jal(3, 24), addi(3, 0, 99), nop(), nop(), nop(), nop());
   setRow(24, "JALR", 4 + 4, 3, addi(1, 0, 20), jalr(3, 1, 4), addi(3, 0, 99),
          nop(), nop(), nop());
   setRow(25, "LUI", 32'h12345 << 12, 3, upper(OPC_LUI, 3, 32'h12345), nop(), nop(), nop(),
          nop(), nop());
   setRow(26, "AUIPC", (32'hABCDE << 12) + 4, 3, nop(), upper(OPC_AUIPC, 3, 32'hABCDE),
          nop(), nop(), nop(), nop());

   // Memory round trip and x0
   setRow(27, "SW then LW", (32'hDEADB << 12) + (-273), 3, upper(OPC_LUI, 1, 32'hDEADB),
          addi(1, 1, -273), sw(1, 0, 32'h80), lw(3, 0, 32'h80), nop(), nop());
   setRow(28, "write x0", 0, 0, addi(0, 0, 55), nop(), nop(), nop(), nop(), nop());
endtask

`endif

/* tbFemtoCore.sv */
// Memory model covers 0x000..0x3FF only; one result store to 0x100 ends each program
`timescale 1ns/1ps

module tbFemtoCore import rvIsaPkg::*, corePkg::*; ();

   localparam int NROWS     = 29;
   localparam int RST_CYC   = 8;
   localparam int LIMIT     = NROWS * 300 + NROWS * RST_CYC;   // Whole run in cycles
   localparam int OPA       = -20;                              // ALU operand in x1
   localparam int OPB       = 7;                                // ALU operand in x2

   logic        clk, reset, memRstrb, memRbusy, memWbusy;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memWmask;

   logic [31:0] mem [256];
   logic [31:0] progWords [NROWS][8];
   logic [31:0] expWord [NROWS];
   string       testName [NROWS];
   logic [31:0] sAddr, sWdata, rdAddr, result;
   logic [3:0]  sMask;
   logic        sStrb, sReset, done, firstSeen;
   int          rdCnt, wrCnt, errors, cycles, failedTests;

   femtoCore u_femtoCore (.*);

   // ************************************************************
   // Instruction encoders straight from the RV32I formats
   // ************************************************************
   function automatic logic [31:0] iType(int imm, int rs1, logic [2:0] f3, int rd,
                                         logic [4:0] opc);
      return {imm[11:0], rs1[4:0], f3, rd[4:0], opc, 2'b11};
   endfunction
   function automatic logic [31:0] addi(int rd, int rs1, int imm);
      return iType(imm, rs1, F3_ADD, rd, OPC_OPIMM);
   endfunction
   function automatic logic [31:0] nop();
      return addi(0, 0, 0);
   endfunction
   function automatic logic [31:0] lw(int rd, int rs1, int imm);
      return iType(imm, rs1, 3'b010, rd, OPC_LOAD);
   endfunction
   function automatic logic [31:0] jalr(int rd, int rs1, int imm);
      return iType(imm, rs1, 3'b000, rd, OPC_JALR);
   endfunction
   function automatic logic [31:0] sw(int rs2, int rs1, int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE, 2'b11};
   endfunction
   function automatic logic [31:0] upper(logic [4:0] opc, int rd, int imm20);
      return {imm20[19:0], rd[4:0], opc, 2'b11};
   endfunction
   function automatic logic [31:0] jal(int rd, int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL, 2'b11};
   endfunction
   function automatic logic [31:0] branch(logic [2:0] f3, int rs1, int rs2, int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH, 2'b11};
   endfunction

   // Reference branch decision from the ISA text
   function automatic logic taken(logic [2:0] f3, int a, int b);
      case (f3)
         F3_BEQ:  return a == b;
         F3_BNE:  return a != b;
         F3_BLT:  return a < b;
         F3_BGE:  return a >= b;
         F3_BLTU: return $unsigned(a) < $unsigned(b);
         default: return $unsigned(a) >= $unsigned(b);   // BGEU
      endcase
   endfunction

   task automatic setRow(int idx, string name, logic [31:0] exp, int res, logic [31:0] w0,
                         logic [31:0] w1, logic [31:0] w2, logic [31:0] w3,
                         logic [31:0] w4, logic [31:0] w5);
      testName[idx]  = name;
      expWord[idx]   = exp;
      progWords[idx] = '{w0, w1, w2, w3, w4, w5, sw(res, 0, 32'h100), jal(0, 0)};
   endtask

   task automatic aluRow(int idx, string name, logic [2:0] f3, int f7, logic [31:0] exp);
      instrWord_t op;                        // R-type x3 <- x1 OP x2
      op.r.funct7 = f7[6:0];
      op.r.rs2    = 5'd2;
      op.r.rs1    = 5'd1;
      op.r.funct3 = f3;
      op.r.rd     = 5'd3;
      op.r.opcode = {OPC_OP, 2'b11};
      setRow(idx, name, exp, 3, addi(1, 0, OPA), addi(2, 0, OPB), op, nop(), nop(), nop());
   endtask

   task automatic branchRow(int idx, string name, logic [2:0] f3, int a, int b);
      // Taken branch skips the marker 2 and lands on the store
      setRow(idx, name, taken(f3, a, b) ? 1 : 2, 3, addi(1, 0, a), addi(2, 0, b),
             addi(3, 0, 1), branch(f3, 1, 2, 8), addi(3, 0, 2), nop());
   endtask

   `include "tbProgramTable.svh"

   task automatic compare(logic [31:0] got, logic [31:0] exp, string what);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   initial clk = 1'b0;
   always #2 clk = ~clk;                     // 4 ns period

   // ************************************************************
   // Memory model with random busy stalls, answers 1 ns after the edge
   // ************************************************************
   always @(posedge clk) begin
      sStrb  = memRstrb;                     // Sampled before the DUT updates
      sAddr  = memAddr;
      sMask  = memWmask;
      sWdata = memWdata;
      sReset = reset;
      #1;
      if (!sReset) begin
         rdCnt = 0;
         wrCnt = 0;
      end else begin
         if (rdCnt > 0) rdCnt--;
         if (wrCnt > 0) wrCnt--;
         if (!firstSeen) begin
            // No write from reset exit up to the first fetch
            compare(32'(sMask), 0, "write mask before first fetch");
         end
         if (sStrb) begin
            rdAddr = sAddr;
            rdCnt  = $urandom % 4;
            if (!firstSeen) begin
               compare(sAddr, 32'(RESET_ADDR), "first read address");
               firstSeen = 1'b1;
            end
         end
         if (sMask != 4'b0000) begin
            compare(32'(sMask), 32'hF, "store write mask");   // Word stores only
            mem[sAddr[9:2]] = sWdata;
            wrCnt = $urandom % 4;
            if (sAddr == 32'h100 && !done) begin
               result = sWdata;
               done   = 1'b1;
            end
         end
      end
      memRbusy = (rdCnt != 0);
      memWbusy = (wrCnt != 0);
      memRdata = mem[rdAddr[9:2]];           // Held stable through the stall
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Timeout: no result store seen within %0d cycles", LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   // ************************************************************
   // Table loop
   // ************************************************************
   initial begin
      int errBefore;
      void'($urandom(91));
      {reset, memRbusy, memWbusy, memRdata} = '0;
      {rdAddr, done, firstSeen, rdCnt, wrCnt, errors, cycles, failedTests} = '0;
      buildTable();
      for (int t = 0; t < NROWS; t++) begin
         @(posedge clk);
         #1 reset = 1'b0;
         repeat (2) @(posedge clk);
         for (int k = 0; k < 256; k++) mem[k] = 32'hA5000000 | (k << 2);   // Address fill
         for (int k = 0; k < 8; k++) mem[k] = progWords[t][k];
         done      = 1'b0;
         firstSeen = 1'b0;
         errBefore = errors;
         repeat (RST_CYC - 2) @(posedge clk);
         #1 reset = 1'b1;
         wait (done);
         compare(result, expWord[t], testName[t]);
         if (errors == errBefore) begin
            $display("%s: ok", testName[t]);
         end else begin
            $display("%s: mismatch", testName[t]);
            failedTests++;
         end
      end
      $display("%0d tests run, %0d failed, %0d errors", NROWS, failedTests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+.
rvIsaPkg.sv
corePkg.sv
execBus.sv
coreSequencer.sv
regFile.sv
execUnit.sv
femtoCore.sv
tbFemtoCore.sv

/* runSim.sh */
#!/bin/sh
# Build and run with Verilator, then decide from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbFemtoCore -f all.f -o simFemto
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simFemto > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0
